//--- hw/change_dispenser.sv
/* Greedy change payout, one coin per cycle after change_load. A new load must not
   arrive before change_done. */

`timescale 1ns/1ps

module change_dispenser (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 change_load,
    input  vending_pkg::credit_t change_amount,
    output vending_pkg::coin_t   coin_return,
    output logic                 change_done
);

    vending_pkg::credit_t remaining;
    logic                 busy;
    vending_pkg::coin_t   next_coin;

    // Largest coin not above what is left
    always_comb begin
        if (remaining >= vending_pkg::coin_value(vending_pkg::DOLLAR)) begin
            next_coin = vending_pkg::DOLLAR;
        end else if (remaining >= vending_pkg::coin_value(vending_pkg::HALF)) begin
            next_coin = vending_pkg::HALF;
        end else if (remaining >= vending_pkg::coin_value(vending_pkg::QUARTER)) begin
            next_coin = vending_pkg::QUARTER;
        end else if (remaining >= vending_pkg::coin_value(vending_pkg::DIME)) begin
            next_coin = vending_pkg::DIME;
        end else if (remaining >= vending_pkg::coin_value(vending_pkg::NICKEL)) begin
            next_coin = vending_pkg::NICKEL;
        end else if (remaining != '0) begin
            next_coin = vending_pkg::PENNY;
        end else begin
            next_coin = vending_pkg::COIN_NONE;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            coin_return <= vending_pkg::COIN_NONE;
            change_done <= 1'b0;
        end else begin
            coin_return <= vending_pkg::COIN_NONE;
            change_done <= 1'b0;
            if (change_load) begin
                busy <= 1'b1;
            end else if (busy) begin
                if (remaining == '0) begin
                    busy        <= 1'b0;
                    change_done <= 1'b1;        // Cycle after the last coin
                end else begin
                    coin_return <= next_coin;
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            remaining <= '0;
        end else if (change_load) begin
            remaining <= change_amount;
        end else if (busy) begin
            remaining <= remaining - vending_pkg::coin_value(next_coin);
        end
    end

endmodule

//--- hw/coin_accumulator.sv
/* Credit register. Coins count only while accept is high, a clear beats a coin in
   the same cycle, and the sum saturates at 1023 cents. */

`timescale 1ns/1ps

`include "vending_defs.svh"

module coin_accumulator (
    input  logic                clock,
    input  logic                reset,
    input  vending_pkg::coin_t  coin_in,
    input  logic                accept,
    input  logic                credit_clear,
    output vending_pkg::credit_t credit
);

    logic [`VM_CREDIT_W:0]  credit_sum;     // One spare bit for overflow
    vending_pkg::credit_t   credit_next;

    ////////////////////////////////////////////////////////////////////////////
    // Next credit
    ////////////////////////////////////////////////////////////////////////////

    assign credit_sum = {1'b0, credit} + {1'b0, vending_pkg::coin_value(coin_in)};

    always_comb begin
        if (credit_sum[`VM_CREDIT_W]) begin
            credit_next = '1;                       // Saturate
        end else begin
            credit_next = credit_sum[`VM_CREDIT_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Credit register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit <= '0;
        end else if (credit_clear) begin
            credit <= '0;
        end else if (accept) begin
            credit <= credit_next;                  // Bad codes add 0
        end
    end

endmodule

//--- hw/credit_display.sv
/* Binary to BCD by shift and add 3, registered once, so the display trails the
   credit by one cycle. */

`timescale 1ns/1ps

`include "vending_defs.svh"

module credit_display (
    input  logic                 clock,
    input  logic                 reset,
    input  vending_pkg::credit_t credit,
    output vending_pkg::bcd_t    display_bcd
);

    vending_pkg::bcd_t bcd_next;

    always_comb begin
        bcd_next = '0;
        for (int i = `VM_CREDIT_W - 1; i >= 0; i--) begin
            for (int d = 0; d < `VM_BCD_DIGITS; d++) begin
                if (bcd_next[d*4 +: 4] >= 4'd5) begin
                    bcd_next[d*4 +: 4] = bcd_next[d*4 +: 4] + 4'd3;  // Digit would pass 9
                end
            end
            bcd_next = {bcd_next[`VM_BCD_DIGITS*4-2:0], credit[i]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            display_bcd <= '0;
        end else begin
            display_bcd <= bcd_next;
        end
    end

endmodule

//--- hw/selection_decoder.sv
/* Buttons are registered once, so picks lag the buttons by a cycle. Rows win
   from A to D and columns from 1 to 5 when several are pressed. */

`timescale 1ns/1ps

`include "vending_defs.svh"

module selection_decoder (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 row_a,
    input  logic                 row_b,
    input  logic                 row_c,
    input  logic                 row_d,
    input  logic                 col_1,
    input  logic                 col_2,
    input  logic                 col_3,
    input  logic                 col_4,
    input  logic                 col_5,
    output logic                 pick_valid,
    output vending_pkg::slot_t   pick_slot,
    output vending_pkg::credit_t pick_price
);

    logic [3:0] row_q;      // Bit 0 is row A
    logic [4:0] col_q;      // Bit 0 is column 1
    logic [1:0] row_idx;
    logic [2:0] col_idx;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            row_q <= '0;
            col_q <= '0;
        end else begin
            row_q <= {row_d, row_c, row_b, row_a};
            col_q <= {col_5, col_4, col_3, col_2, col_1};
        end
    end

    always_comb begin
        if (row_q[0])      row_idx = 2'd0;
        else if (row_q[1]) row_idx = 2'd1;
        else if (row_q[2]) row_idx = 2'd2;
        else               row_idx = 2'd3;

        if (col_q[0])      col_idx = 3'd0;
        else if (col_q[1]) col_idx = 3'd1;
        else if (col_q[2]) col_idx = 3'd2;
        else if (col_q[3]) col_idx = 3'd3;
        else               col_idx = 3'd4;

        case (row_idx)
            2'd0:    pick_price = vending_pkg::credit_t'(`VM_PRICE_A);
            2'd1:    pick_price = vending_pkg::credit_t'(`VM_PRICE_B);
            2'd2:    pick_price = vending_pkg::credit_t'(`VM_PRICE_C);
            default: pick_price = vending_pkg::credit_t'(`VM_PRICE_D);
        endcase
    end

    assign pick_valid = (|row_q) && (|col_q);
    assign pick_slot  = {3'b000, row_idx} * 5'd5 + {2'b00, col_idx} + 5'd1;  // A1 is 1

endmodule

//--- hw/vend_controller.sv
/* Transaction FSM. Coins are taken only in IDLE and COLLECTING, and the slot is
   held until the drop sensor fires, with no timeout on that wait. */

`timescale 1ns/1ps

module vend_controller (
    input  logic                 clock,
    input  logic                 reset,
    input  vending_pkg::credit_t credit,
    input  logic                 pick_valid,
    input  vending_pkg::slot_t   pick_slot,
    input  vending_pkg::credit_t pick_price,
    input  logic                 food_dispensed,
    input  logic                 change_done,
    output logic                 accept,
    output logic                 credit_clear,
    output vending_pkg::slot_t   vend_slot,
    output logic                 change_load,
    output vending_pkg::credit_t change_amount
);

    vending_pkg::vend_state_t state;
    vending_pkg::credit_t     price_q;      // Price of the row being vended
    logic                     pick_ok;
    logic                     drop_seen;

    ////////////////////////////////////////////////////////////////////////////
    // Decisions
    ////////////////////////////////////////////////////////////////////////////

    assign pick_ok   = (state == vending_pkg::COLLECTING) && pick_valid &&
                       (credit >= pick_price);
    assign drop_seen = (state == vending_pkg::VENDING) && food_dispensed;

    assign accept = (state == vending_pkg::IDLE) || (state == vending_pkg::COLLECTING);

    ////////////////////////////////////////////////////////////////////////////
    // State and strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= vending_pkg::IDLE;
            vend_slot    <= '0;
            credit_clear <= 1'b0;
            change_load  <= 1'b0;
        end else begin
            credit_clear <= 1'b0;       // Both strobes last one cycle
            change_load  <= 1'b0;

            case (state)
                vending_pkg::IDLE: begin
                    if (credit != '0) begin
                        state <= vending_pkg::COLLECTING;
                    end
                end

                vending_pkg::COLLECTING: begin
                    if (pick_ok) begin
                        vend_slot <= pick_slot;
                        state     <= vending_pkg::VENDING;
                    end
                end

                vending_pkg::VENDING: begin
                    // Slot stays up until the sensor sees the drop
                    if (drop_seen) begin
                        vend_slot    <= '0;
                        credit_clear <= 1'b1;
                        change_load  <= 1'b1;
                        state        <= vending_pkg::RETURNING;
                    end
                end

                vending_pkg::RETURNING: begin
                    if (change_done) begin
                        state <= vending_pkg::IDLE;
                    end
                end

                default: begin
                    state <= vending_pkg::IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Price and change amount
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            price_q       <= '0;
            change_amount <= '0;
        end else begin
            if (pick_ok) begin
                price_q <= pick_price;
            end
            if (drop_seen) begin
                change_amount <= credit - price_q;  // Credit covered the price at pick
            end
        end
    end

endmodule

//--- hw/vending_defs.svh
/* Widths, row prices and coin values in cents. Credit must stay below 1024, and
   the display holds four decimal digits. */

`ifndef VENDING_DEFS_SVH
`define VENDING_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

`define VM_CREDIT_W     10      // Cents up to 1023
`define VM_COIN_W       3
`define VM_SLOT_W       5       // 1 to 20 valid and 0 for none
`define VM_BCD_DIGITS   4

////////////////////////////////////////////////////////////////////////////
// Row prices and coin values
////////////////////////////////////////////////////////////////////////////

`define VM_PRICE_A      100
`define VM_PRICE_B      125
`define VM_PRICE_C      150
`define VM_PRICE_D      175

`define VM_VAL_PENNY    1
`define VM_VAL_NICKEL   5
`define VM_VAL_DIME     10
`define VM_VAL_QUARTER  25
`define VM_VAL_HALF     50
`define VM_VAL_DOLLAR   100

`endif

//--- hw/vending_machine.sv
/* Vending controller top, 20 slots in rows A to D. Buttons and the drop sensor are
   levels, coin_in is a one cycle strobe per coin. */

`timescale 1ns/1ps

module vending_machine (
    input  logic               clock,
    input  logic               reset,
    input  vending_pkg::coin_t coin_in,
    input  logic               row_a,
    input  logic               row_b,
    input  logic               row_c,
    input  logic               row_d,
    input  logic               col_1,
    input  logic               col_2,
    input  logic               col_3,
    input  logic               col_4,
    input  logic               col_5,
    input  logic               food_dispensed,
    output vending_pkg::slot_t vend_slot,
    output vending_pkg::coin_t coin_return,
    output logic               change_done,
    output vending_pkg::bcd_t  display_bcd
);

    vending_pkg::credit_t credit;
    vending_pkg::credit_t pick_price;
    vending_pkg::credit_t change_amount;
    vending_pkg::slot_t   pick_slot;
    logic                 pick_valid;
    logic                 accept;
    logic                 credit_clear;
    logic                 change_load;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    coin_accumulator i_coin_accumulator (
        .clock(clock), .reset(reset), .coin_in(coin_in), .accept(accept),
        .credit_clear(credit_clear), .credit(credit)
    );

    selection_decoder i_selection_decoder (
        .clock(clock), .reset(reset),
        .row_a(row_a), .row_b(row_b), .row_c(row_c), .row_d(row_d),
        .col_1(col_1), .col_2(col_2), .col_3(col_3), .col_4(col_4), .col_5(col_5),
        .pick_valid(pick_valid), .pick_slot(pick_slot), .pick_price(pick_price)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control and output side
    ////////////////////////////////////////////////////////////////////////////

    vend_controller i_vend_controller (
        .clock(clock), .reset(reset), .credit(credit),
        .pick_valid(pick_valid), .pick_slot(pick_slot), .pick_price(pick_price),
        .food_dispensed(food_dispensed), .change_done(change_done),
        .accept(accept), .credit_clear(credit_clear), .vend_slot(vend_slot),
        .change_load(change_load), .change_amount(change_amount)
    );

    change_dispenser i_change_dispenser (
        .clock(clock), .reset(reset), .change_load(change_load),
        .change_amount(change_amount), .coin_return(coin_return),
        .change_done(change_done)
    );

    credit_display i_credit_display (
        .clock(clock), .reset(reset), .credit(credit), .display_bcd(display_bcd)
    );

endmodule

//--- hw/vending_pkg.sv
/* Shared types of the vending controller. Coin codes 1 to 6 are ordered by value,
   and coin_value gives 0 for COIN_NONE and COIN_BAD. */

package vending_pkg;

    `include "vending_defs.svh"

    typedef logic [`VM_CREDIT_W-1:0] credit_t;      // Cents
    typedef logic [`VM_SLOT_W-1:0] slot_t;
    typedef logic [`VM_BCD_DIGITS*4-1:0] bcd_t;     // Most significant digit on top

    typedef enum logic [`VM_COIN_W-1:0] {
        COIN_NONE = 3'd0,
        PENNY     = 3'd1,
        NICKEL    = 3'd2,
        DIME      = 3'd3,
        QUARTER   = 3'd4,
        HALF      = 3'd5,
        DOLLAR    = 3'd6,
        COIN_BAD  = 3'd7
    } coin_t;

    typedef enum logic [1:0] {
        IDLE,
        COLLECTING,
        VENDING,
        RETURNING
    } vend_state_t;

    function automatic credit_t coin_value(input coin_t coin);
        case (coin)
            PENNY:   return credit_t'(`VM_VAL_PENNY);
            NICKEL:  return credit_t'(`VM_VAL_NICKEL);
            DIME:    return credit_t'(`VM_VAL_DIME);
            QUARTER: return credit_t'(`VM_VAL_QUARTER);
            HALF:    return credit_t'(`VM_VAL_HALF);
            DOLLAR:  return credit_t'(`VM_VAL_DOLLAR);
            default: return '0;                     // No coin or unknown code
        endcase
    endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module vending_machine_tb -f vending_machine.f -o vending_sim \
    > build.log 2>&1 \
    && ./obj_dir/vending_sim > sim.log 2>&1

grep -q "SIMULATION PASSED" sim.log \
    && echo "Run passed" \
    || { cat build.log sim.log 2>/dev/null; echo "Run failed"; exit 1; }

//--- vending_machine.f
+incdir+hw
+incdir+verification
hw/vending_pkg.sv
hw/coin_accumulator.sv
hw/selection_decoder.sv
hw/vend_controller.sv
hw/change_dispenser.sv
hw/credit_display.sv
hw/vending_machine.sv
verification/vending_machine_tb.sv

//--- verification/vending_machine_tests.svh
/* Directed tests, included into the testbench module body. Each one starts with
   the machine idle and zero credit, and leaves it that way. */

`ifndef VENDING_MACHINE_TESTS_SVH
`define VENDING_MACHINE_TESTS_SVH

    task automatic test_credit_counting();
        vending_pkg::coin_t coin;
        int count;
        paid  = 0;
        count = 6 + int'($urandom_range(3));        // Stays below 1024 cents
        for (int i = 0; i < count; i++) begin
            if (i == count / 2) begin
                coin = vending_pkg::COIN_BAD;
            end else begin
                coin = vending_pkg::coin_t'(3'($urandom_range(7, 1)));
            end
            insert_coin(coin);
            @(negedge clock);                       // Display lags one cycle
            check_bcd("display_bcd", display_bcd, decimal_digits(paid));
        end
        apply_reset();
    endtask

    task automatic test_price_gating();
        paid = 0;
        insert_coin(vending_pkg::DOLLAR);
        insert_coin(vending_pkg::DIME);
        set_buttons(1, 3);                          // B4 costs more than the credit
        repeat (6) begin
            @(negedge clock);
            check_slot("vend_slot", vend_slot, '0);
        end
        set_buttons(0, 2);                          // A3
        wait_slot();
        check_slot("vend_slot", vend_slot, slot_of(0, 2));
        release_buttons();
        finish_vend(slot_of(0, 2), 2, paid - row_price(0));
    endtask

    task automatic test_vend_and_change();
        paid = 0;
        insert_coin(vending_pkg::DOLLAR);
        insert_coin(vending_pkg::HALF);
        insert_coin(vending_pkg::QUARTER);
        insert_coin(vending_pkg::DIME);
        insert_coin(vending_pkg::NICKEL);
        insert_coin(vending_pkg::PENNY);
        @(negedge clock);
        check_bcd("display_bcd", display_bcd, decimal_digits(paid));
        set_buttons(3, 1);                          // D2
        wait_slot();
        check_slot("vend_slot", vend_slot, slot_of(3, 1));
        release_buttons();
        finish_vend(slot_of(3, 1), 3, paid - row_price(3));
        check_bcd("display_bcd", display_bcd, decimal_digits(0));
    endtask

    task automatic test_exact_price();
        paid = 0;
        insert_coin(vending_pkg::DOLLAR);
        set_buttons(0, 0);                          // A1
        wait_slot();
        check_slot("vend_slot", vend_slot, slot_of(0, 0));
        release_buttons();
        finish_vend(slot_of(0, 0), 1, paid - row_price(0));
    endtask

    task automatic test_coins_while_vending();
        paid = 0;
        insert_coin(vending_pkg::DOLLAR);
        insert_coin(vending_pkg::HALF);
        insert_coin(vending_pkg::QUARTER);
        insert_coin(vending_pkg::DIME);
        set_buttons(2, 4);                          // C5
        wait_slot();
        check_slot("vend_slot", vend_slot, slot_of(2, 4));
        release_buttons();
        coin_in = vending_pkg::DOLLAR;              // Lands in VENDING
        @(negedge clock);
        coin_in = vending_pkg::COIN_NONE;
        @(negedge clock);
        check_bcd("display_bcd", display_bcd, decimal_digits(paid));
        food_dispensed = 1'b1;
        @(negedge clock);
        food_dispensed = 1'b0;
        coin_in = vending_pkg::HALF;                // These two land in RETURNING
        @(negedge clock);
        coin_in = vending_pkg::DIME;
        @(negedge clock);
        coin_in = vending_pkg::COIN_NONE;
        collect_change(paid - row_price(2));
        check_bcd("display_bcd", display_bcd, decimal_digits(0));

        // Next customer starts from zero
        paid = 0;
        insert_coin(vending_pkg::NICKEL);
        @(negedge clock);
        check_bcd("display_bcd", display_bcd, decimal_digits(paid));
        apply_reset();
    endtask

    task automatic test_reset_mid_vend();
        paid = 0;
        insert_coin(vending_pkg::DOLLAR);
        insert_coin(vending_pkg::QUARTER);
        set_buttons(1, 0);                          // B1
        wait_slot();
        check_slot("vend_slot", vend_slot, slot_of(1, 0));
        release_buttons();
        reset = 1'b1;
        repeat (4) begin
            @(negedge clock);
            check_slot("vend_slot", vend_slot, '0);
            check_bcd("display_bcd", display_bcd, decimal_digits(0));
            check_coin("coin_return", coin_return, vending_pkg::COIN_NONE);
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clock);
            check_slot("vend_slot", vend_slot, '0);
            check_coin("coin_return", coin_return, vending_pkg::COIN_NONE);
        end
    endtask

`endif

//--- verification/vending_machine_tb.sv
/* Directed testbench. Inputs change and outputs are sampled on the falling edge,
   and the run stops at the first mismatch. */

`timescale 1ns/1ps

`include "vending_defs.svh"

module vending_machine_tb;

    localparam int WAIT_LIMIT = 100;        // Cycles allowed per wait

    logic               clock;
    logic               reset;
    vending_pkg::coin_t coin_in;
    logic               row_a, row_b, row_c, row_d;
    logic               col_1, col_2, col_3, col_4, col_5;
    logic               food_dispensed;
    vending_pkg::slot_t vend_slot;
    vending_pkg::coin_t coin_return;
    logic               change_done;
    vending_pkg::bcd_t  display_bcd;

    vending_pkg::coin_t expected_coins[$];
    vending_pkg::coin_t returned_coins[$];
    int                 paid;               // Cents accepted in this transaction

    vending_machine i_dut (
        .clock(clock), .reset(reset), .coin_in(coin_in),
        .row_a(row_a), .row_b(row_b), .row_c(row_c), .row_d(row_d),
        .col_1(col_1), .col_2(col_2), .col_3(col_3), .col_4(col_4), .col_5(col_5),
        .food_dispensed(food_dispensed), .vend_slot(vend_slot),
        .coin_return(coin_return), .change_done(change_done), .display_bcd(display_bcd)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_credit(input string name, input vending_pkg::credit_t got,
                                input vending_pkg::credit_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_slot(input string name, input vending_pkg::slot_t got,
                              input vending_pkg::slot_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_coin(input string name, input vending_pkg::coin_t got,
                              input vending_pkg::coin_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bcd(input string name, input vending_pkg::bcd_t got,
                             input vending_pkg::bcd_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference values
    ////////////////////////////////////////////////////////////////////////////

    function automatic int coin_cents(input vending_pkg::coin_t coin);
        case (coin)
            vending_pkg::PENNY:   return `VM_VAL_PENNY;
            vending_pkg::NICKEL:  return `VM_VAL_NICKEL;
            vending_pkg::DIME:    return `VM_VAL_DIME;
            vending_pkg::QUARTER: return `VM_VAL_QUARTER;
            vending_pkg::HALF:    return `VM_VAL_HALF;
            vending_pkg::DOLLAR:  return `VM_VAL_DOLLAR;
            default:              return 0;
        endcase
    endfunction

    function automatic int row_price(input int row);
        case (row)
            0:       return `VM_PRICE_A;
            1:       return `VM_PRICE_B;
            2:       return `VM_PRICE_C;
            default: return `VM_PRICE_D;
        endcase
    endfunction

    function automatic vending_pkg::slot_t slot_of(input int row, input int col);
        return vending_pkg::slot_t'(row * 5 + col + 1);    // A1 is slot 1
    endfunction

    function automatic vending_pkg::bcd_t decimal_digits(input int value);
        return {4'(value / 1000 % 10), 4'(value / 100 % 10),
                4'(value / 10 % 10), 4'(value % 10)};
    endfunction

    // Largest coin first until nothing is left
    task automatic plan_change(input int amount);
        vending_pkg::coin_t pick;
        int left;
        left = amount;
        expected_coins.delete();
        while (left > 0) begin
            for (int code = 6; code >= 1; code--) begin
                pick = vending_pkg::coin_t'(3'(code));
                if (coin_cents(pick) <= left) begin
                    break;
                end
            end
            expected_coins.push_back(pick);
            left -= coin_cents(pick);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers and waits
    ////////////////////////////////////////////////////////////////////////////

    task automatic insert_coin(input vending_pkg::coin_t coin);
        coin_in = coin;
        @(negedge clock);
        coin_in = vending_pkg::COIN_NONE;
        paid += coin_cents(coin);
    endtask

    task automatic set_buttons(input int row, input int col);
        row_a = (row == 0);
        row_b = (row == 1);
        row_c = (row == 2);
        row_d = (row == 3);
        col_1 = (col == 0);
        col_2 = (col == 1);
        col_3 = (col == 2);
        col_4 = (col == 3);
        col_5 = (col == 4);
    endtask

    task automatic release_buttons();
        set_buttons(-1, -1);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
    endtask

    task automatic wait_slot();
        int cycles;
        cycles = 0;
        while (vend_slot == '0) begin
            if (cycles == WAIT_LIMIT) begin
                fail_run("Timeout: no slot was vended after a valid selection");
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic wait_change_done();
        int cycles;
        cycles = 0;
        returned_coins.delete();
        while (change_done !== 1'b1) begin
            if (coin_return != vending_pkg::COIN_NONE) begin
                returned_coins.push_back(coin_return);
            end
            if (cycles == WAIT_LIMIT) begin
                fail_run("Timeout: change_done never arrived");
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic collect_change(input int amount);
        int total;
        total = 0;
        plan_change(amount);
        wait_change_done();
        foreach (returned_coins[i]) begin
            if (i > 0 && coin_cents(returned_coins[i]) > coin_cents(returned_coins[i-1])) begin
                fail_run("Change coins were not paid largest first");
            end
            total += coin_cents(returned_coins[i]);
        end
        check_credit("change total", vending_pkg::credit_t'(total),
                     vending_pkg::credit_t'(amount));
        if (returned_coins.size() != expected_coins.size()) begin
            fail_run($sformatf("Change of %0d cents came as %0d coins instead of %0d",
                               amount, returned_coins.size(), expected_coins.size()));
        end
        foreach (returned_coins[i]) begin
            check_coin("coin_return", returned_coins[i], expected_coins[i]);
        end
        @(negedge clock);                   // Controller back in IDLE
    endtask

    task automatic finish_vend(input vending_pkg::slot_t slot, input int hold,
                               input int change);
        repeat (hold) begin
            @(negedge clock);
            check_slot("vend_slot", vend_slot, slot);
        end
        food_dispensed = 1'b1;
        @(negedge clock);
        food_dispensed = 1'b0;
        check_slot("vend_slot", vend_slot, '0);
        collect_change(change);
    endtask

    `include "vending_machine_tests.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h9009_267d));
        reset          = 1'b1;
        coin_in        = vending_pkg::COIN_NONE;
        food_dispensed = 1'b0;
        paid           = 0;
        release_buttons();
        repeat (4) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        test_credit_counting();
        test_price_gating();
        test_vend_and_change();
        test_exact_price();
        test_coins_while_vending();
        test_reset_mid_vend();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
